// File: source/motorPkg.sv
package motorPkg;

    // Register map, one byte address per word
    localparam logic [7:0] addrCtrl   = 8'h00;
    localparam logic [7:0] addrPeriod = 8'h04;
    localparam logic [7:0] addrStatus = 8'h08;
    localparam logic [7:0] addrRounds = 8'h0C;

    // Step timing
    localparam int periodWidth = 25;
    localparam logic [periodWidth-1:0] defaultPeriod = 25'd1000;
    localparam logic [periodWidth-1:0] minPeriod = 25'd2;

    // Commutation angles
    localparam int stepCount = 12;
    localparam int stepWidth = 4;
    localparam int phaseOffsetB = 8;
    localparam int phaseOffsetC = 4;

    // Gate blanking after a change of level
    localparam int deadTime = 4;
    localparam int deadWidth = $clog2(deadTime + 1);

    localparam int roundWidth = 16;

    // Angle plus a phase offset, modulo one electrical rotation
    function automatic logic [stepWidth-1:0] addOffset(
        input logic [stepWidth-1:0] angle,
        input int                   offset
    );
        int sum;
        sum = int'(angle) + offset;
        if (sum >= stepCount) begin
            sum = sum - stepCount;
        end
        return stepWidth'(sum);
    endfunction

endpackage

// File: source/stepIf.sv
interface stepIf;
    import motorPkg::*;

    logic [stepWidth-1:0] stepA;
    logic [stepWidth-1:0] stepB;
    logic [stepWidth-1:0] stepC;
    // Last cycle of a step
    logic                 stepTick;
    logic                 running;

    modport gen (
        output stepA, stepB, stepC, stepTick, running
    );

    modport drv (
        input stepA, stepB, stepC, stepTick, running
    );

endinterface

// File: source/motorRegs.sv
module motorRegs (
    input  logic                             clk,
    input  logic                             arstN,
    input  logic [7:0]                       paddr,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [31:0]                      pwdata,
    output logic [31:0]                      prdata,
    output logic                             pready,
    output logic                             pslverr,
    output logic                             start,
    output logic [motorPkg::periodWidth-1:0] period,
    input  logic [motorPkg::stepWidth-1:0]   stepA,
    input  logic                             running,
    input  logic [motorPkg::roundWidth-1:0]  rounds
);
    import motorPkg::*;

    logic                   access;
    logic                   mapped;
    logic [periodWidth-1:0] wrPeriod;
    logic [periodWidth-1:0] newPeriod;

    // Access phase of an APB transfer
    assign access = psel && penable;

    // No wait states
    assign pready = 1'b1;
    assign pslverr = access && !mapped;

    assign wrPeriod = pwdata[periodWidth-1:0];
    // Clamp short periods
    assign newPeriod = (wrPeriod < minPeriod) ? minPeriod : wrPeriod;

    always_comb begin
        mapped = 1'b1;
        prdata = '0;
        case (paddr)
            addrCtrl: begin
                prdata[0] = start;
            end
            addrPeriod: begin
                prdata[periodWidth-1:0] = period;
            end
            addrStatus: begin
                prdata[stepWidth-1:0] = stepA;
                prdata[8] = running;
            end
            addrRounds: begin
                prdata[roundWidth-1:0] = rounds;
            end
            default: begin
                mapped = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            start  <= 1'b0;
            period <= defaultPeriod;
        end else if (access && pwrite) begin
            case (paddr)
                addrCtrl: begin
                    start <= pwdata[0];
                end
                addrPeriod: begin
                    period <= newPeriod;
                end
                // STATUS and ROUNDS are read only
                default: begin
                    start  <= start;
                    period <= period;
                end
            endcase
        end
    end

    // Error response only in an access phase that followed a setup phase
    assert property (@(posedge clk) disable iff (!arstN)
        pslverr |-> access && $past(psel && !penable));

endmodule

// File: source/stepGenerator.sv
module stepGenerator (
    input  logic                             clk,
    input  logic                             arstN,
    input  logic                             start,
    input  logic [motorPkg::periodWidth-1:0] period,
    output logic [motorPkg::roundWidth-1:0]  rounds,
    stepIf.gen                               steps
);
    import motorPkg::*;

    logic                   startD;
    logic                   startUp;
    logic                   running;
    logic                   lastCycle;
    logic [periodWidth-1:0] cnt;
    logic [stepWidth-1:0]   angle;

    assign startUp = start && !startD;

    // Count of 1 or less ends the step
    assign lastCycle = (cnt[periodWidth-1:1] == '0);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            startD <= 1'b0;
        end else begin
            startD <= start;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            running <= 1'b0;
            cnt     <= defaultPeriod;
            angle   <= '0;
            rounds  <= '0;
        end else if (!start) begin
            running <= 1'b0;
            cnt     <= period;
            angle   <= '0;
            rounds  <= '0;
        end else if (startUp) begin
            running <= 1'b1;
            cnt     <= period;
            angle   <= '0;
        end else if (running) begin
            if (lastCycle) begin
                // New period applies from here
                cnt <= period;
                if (angle == stepWidth'(stepCount - 1)) begin
                    angle  <= '0;
                    rounds <= rounds + 1'b1;
                end else begin
                    angle <= angle + 1'b1;
                end
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    assign steps.stepA = angle;
    assign steps.stepB = addOffset(angle, phaseOffsetB);
    assign steps.stepC = addOffset(angle, phaseOffsetC);
    assign steps.stepTick = running && lastCycle;
    assign steps.running = running;

    // All three angles stay inside one electrical rotation
    assert property (@(posedge clk) disable iff (!arstN)
        steps.stepA < stepWidth'(stepCount) && steps.stepB < stepWidth'(stepCount)
        && steps.stepC < stepWidth'(stepCount));

endmodule

// File: source/phaseDriver.sv
module phaseDriver (
    input  logic       clk,
    input  logic       arstN,
    stepIf.drv         steps,
    output logic [2:0] gateHigh,
    output logic [2:0] gateLow
);
    import motorPkg::*;

    logic [stepWidth-1:0] angle [3];

    assign angle[0] = steps.stepA;
    assign angle[1] = steps.stepB;
    assign angle[2] = steps.stepC;

    for (genvar i = 0; i < 3; i++) begin : gPhase
        logic                 target;
        logic                 level;
        logic [deadWidth-1:0] deadCnt;

        // High for angles 0 to 5
        assign target = angle[i] < stepWidth'(stepCount / 2);

        always_ff @(posedge clk or negedge arstN) begin
            if (!arstN) begin
                level   <= 1'b0;
                deadCnt <= deadWidth'(deadTime);
            end else if (!steps.running || target != level) begin
                // Blank both gates on a new level and while idle
                level   <= target;
                deadCnt <= deadWidth'(deadTime);
            end else if (deadCnt != '0) begin
                deadCnt <= deadCnt - 1'b1;
            end
        end

        assign gateHigh[i] = steps.running && level && (deadCnt == '0);
        assign gateLow[i] = steps.running && !level && (deadCnt == '0);

        // No gate turns on while or right after its partner was on
        assert property (@(posedge clk) disable iff (!arstN)
            !(gateHigh[i] && (gateLow[i] || $past(gateLow[i])))
            && !(gateLow[i] && $past(gateHigh[i])));

        // Level only moves right after the generator advanced the angle
        assert property (@(posedge clk) disable iff (!arstN)
            steps.running && target != level |-> $past(steps.stepTick));
    end

endmodule

// File: source/motorCtrl.sv
module motorCtrl (
    input  logic        clk,
    input  logic        arstN,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic [2:0]  gateHigh,
    output logic [2:0]  gateLow
);
    import motorPkg::*;

    logic                   start;
    logic [periodWidth-1:0] period;
    logic [roundWidth-1:0]  rounds;

    stepIf steps ();

    motorRegs i_motorRegs (
        .clk     (clk),
        .arstN   (arstN),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .start   (start),
        .period  (period),
        .stepA   (steps.stepA),
        .running (steps.running),
        .rounds  (rounds)
    );

    stepGenerator i_stepGenerator (
        .clk    (clk),
        .arstN  (arstN),
        .start  (start),
        .period (period),
        .rounds (rounds),
        .steps  (steps.gen)
    );

    phaseDriver i_phaseDriver (
        .clk      (clk),
        .arstN    (arstN),
        .steps    (steps.drv),
        .gateHigh (gateHigh),
        .gateLow  (gateLow)
    );

endmodule

// File: test/motorCtrlTb.sv
module motorCtrlTb;

    logic        clk;
    logic        arstN;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [2:0]  gateHigh;
    logic [2:0]  gateLow;

    int passCount;
    int failCount;

    motorCtrl i_motorCtrl (
        .clk      (clk),
        .arstN    (arstN),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .gateHigh (gateHigh),
        .gateLow  (gateLow)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Setup phase, access phase, then back to idle
    task automatic apbTransfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                               output logic [31:0] rdata, output logic err);
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= wr;
        pwdata  <= data;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        if (pready !== 1'b1) begin
            failCount++;
            $display("APB transfer to address %0h was not ready in its access phase", addr);
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    // Gate pattern for phase A angle, B at A+8 and C at A+4
    function automatic logic [5:0] gatesFor(input int angleA);
        logic [2:0] high;
        high[0] = (angleA % 12) < 6;
        high[1] = ((angleA + 8) % 12) < 6;
        high[2] = ((angleA + 4) % 12) < 6;
        return {high, ~high};
    endfunction

    // Poll STATUS until the angle moves away from prev
    task automatic waitAngleChange(input int prev, output int angle, output logic [31:0] status,
                                   output logic timedOut);
        logic err;
        int   polls;
        polls = 0;
        timedOut = 1'b0;
        apbTransfer(1'b0, 8'h08, '0, status, err);
        while (int'(status[3:0]) == prev && polls < 100) begin
            apbTransfer(1'b0, 8'h08, '0, status, err);
            polls++;
        end
        angle = int'(status[3:0]);
        if (polls >= 100) begin
            timedOut = 1'b1;
        end
    endtask

    task automatic report(input logic ok, input logic [8*32-1:0] name, input logic [31:0] exp,
                          input logic [31:0] act);
        if (ok) begin
            passCount++;
            $display("[PASS] %0s", name);
        end else begin
            failCount++;
            $display("[FAIL] %0s expected %0h actual %0h", name, exp, act);
        end
    endtask

    task automatic failPlain(input logic [8*32-1:0] name, input string what);
        failCount++;
        $display("%0s: %0s", name, what);
    endtask

    task automatic runCase(input logic [8*12-1:0] op, input logic [7:0] addr,
                           input logic [31:0] data, input logic [31:0] exp,
                           input logic [8*32-1:0] name);
        logic [31:0] rdata;
        logic [31:0] status;
        logic        err;
        logic        timedOut;
        logic        wasHigh;
        logic        ok;
        int          prev;
        int          angle;
        int          offCycles;
        int          waited;
        ok = 1'b1;
        if (op == "write") begin
            apbTransfer(1'b1, addr, data, rdata, err);
            report(err == exp[0], name, exp, {31'b0, err});
        end else if (op == "read") begin
            apbTransfer(1'b0, addr, '0, rdata, err);
            report(rdata == exp, name, exp, rdata);
        end else if (op == "readerr") begin
            apbTransfer(1'b0, addr, '0, rdata, err);
            report(err == exp[0], name, exp, {31'b0, err});
        end else if (op == "gatesnow") begin
            repeat (2) @(negedge clk);
            report({gateHigh, gateLow} == exp[5:0], name, exp, {26'b0, gateHigh, gateLow});
        end else if (op == "steps") begin
            apbTransfer(1'b0, 8'h08, '0, status, err);
            prev = int'(status[3:0]);
            for (int i = 0; i < int'(data) && ok; i++) begin
                waitAngleChange(prev, angle, status, timedOut);
                if (timedOut) begin
                    failPlain(name, "timeout, STATUS angle stopped advancing");
                    return;
                end
                if (angle != (prev + 1) % 12 || !status[8]) begin
                    ok = 1'b0;
                    report(1'b0, name, 32'h100 | ((prev + 1) % 12), status);
                end
                prev = angle;
            end
            if (ok) begin
                report(status == exp, name, exp, status);
            end
        end else if (op == "gates") begin
            apbTransfer(1'b0, 8'h08, '0, status, err);
            prev = int'(status[3:0]);
            for (int i = 0; i < int'(data) && ok; i++) begin
                waitAngleChange(prev, angle, status, timedOut);
                if (timedOut) begin
                    failPlain(name, "timeout, STATUS angle stopped advancing");
                    return;
                end
                prev = angle;
                // Past dead time
                repeat (6) @(negedge clk);
                if ({gateHigh, gateLow} != gatesFor(angle)) begin
                    ok = 1'b0;
                    report(1'b0, name, gatesFor(angle), {gateHigh, gateLow});
                end
            end
            if (ok) begin
                report(1'b1, name, '0, '0);
            end
        end else if (op == "dead") begin
            waited = 0;
            @(negedge clk);
            while (!(gateHigh[0] || gateLow[0]) && waited < 1000) begin
                @(negedge clk);
                waited++;
            end
            wasHigh = gateHigh[0];
            while ((gateHigh[0] || gateLow[0]) && waited < 1000) begin
                @(negedge clk);
                waited++;
            end
            if (waited >= 1000) begin
                failPlain(name, "timeout, phase A gates never changed");
                return;
            end
            offCycles = 0;
            while (!(gateHigh[0] || gateLow[0]) && offCycles < 100) begin
                offCycles++;
                @(negedge clk);
            end
            if (offCycles != int'(exp)) begin
                report(1'b0, name, exp, offCycles);
            end else if (gateHigh[0] == wasHigh) begin
                failPlain(name, "the same gate of phase A came back on after dead time");
            end else begin
                report(1'b1, name, exp, offCycles);
            end
        end else begin
            failPlain(name, "unknown operation in the cases file");
        end
    endtask

    initial begin
        int                fd;
        int                fields;
        string             line;
        logic [8*12-1:0]   op;
        logic [8*32-1:0]   name;
        logic [31:0]       addr;
        logic [31:0]       data;
        logic [31:0]       exp;
        passCount = 0;
        failCount = 0;
        arstN   = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        repeat (2) @(posedge clk);
        arstN <= 1'b1;
        fd = $fopen("test/motorCases.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/motorCases.txt");
            failCount++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                fields = $fgets(line, fd);
                if (fields > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%s %h %h %h %s", op, addr, data, exp, name);
                    if (fields == 5) begin
                        runCase(op, addr[7:0], data, exp, name);
                    end
                end
            end
            $fclose(fd);
        end
        $display("Tests: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0 && passCount > 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: test/motorCases.txt
# op addr data expected name, numbers in hex
# data is a step count for steps and gates, expected is pslverr for write and readerr
gatesnow 0 0 0 resetGates
read 0 0 0 resetCtrl
read 4 0 3e8 resetPeriod
read c 0 0 resetRounds
write 4 14 0 writePeriod
read 4 0 14 readPeriod
write 4 1 0 writeShortPeriod
read 4 0 2 clampPeriod
readerr 10 0 1 unmappedRead
write 8 f 0 writeStatus
read 8 0 0 statusUnchanged
write 4 8 0 setPeriod8
write 0 1 0 startMotor
steps 0 c 100 stepSequence
write 0 0 0 stopForGates
write 4 28 0 setPeriod40
write 0 1 0 restartForGates
gates 0 c 0 gateLevels
dead 0 0 4 deadTimeA
write 0 0 0 stopForRounds
write 4 8 0 setPeriodRounds
write 0 1 0 restartForRounds
steps 0 24 100 threeRotations
read c 0 3 roundsAfterThree
write 0 0 0 stopMotor
gatesnow 0 0 0 gatesOffAfterStop
read 8 0 0 statusAfterStop
read c 0 0 roundsAfterStop

// File: list.f
source/motorPkg.sv
source/stepIf.sv
source/motorRegs.sv
source/stepGenerator.sv
source/phaseDriver.sv
source/motorCtrl.sv
test/motorCtrlTb.sv

// File: Makefile
OBJ = obj_dir

all: run

build:
	verilator --binary --timing --assert -f list.f --top-module motorCtrlTb -Mdir $(OBJ)

run: build
	./$(OBJ)/VmotorCtrlTb > sim.log 2>&1; cat sim.log
	! grep -q "Simulation FAILED" sim.log
	grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only --timing -f list.f --top-module motorCtrlTb

clean:
	rm -rf $(OBJ) sim.log

.PHONY: all build run lint clean
